// File: sources.f
hdl/afifo_pkg.sv
hdl/fifo_wr_if.sv
hdl/fifo_rd_if.sv
hdl/cdc_sync.sv
hdl/gray_ptr_counter.sv
hdl/ram_t2p_asym.sv
hdl/async_fifo_asym.sv
hdl/byte_producer.sv
hdl/word_consumer.sv
hdl/stream_width_top.sv
dv/tb_stream_width.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the stream width bridge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal \
      --top-module tb_stream_width -f sources.f; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_stream_width)
sim_rc=$?
echo "$sim_out"

if [ "$sim_rc" -ne 0 ]; then
   echo "simulation exited with status $sim_rc"
   exit 1
fi

if grep -qF '** PASS **' <<< "$sim_out"; then
   exit 0
else
   echo "pass message not found in simulation output"
   exit 1
fi

// File: dv/tb_stream_width.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stream_width
   import afifo_pkg::*;
();

   localparam int ADDR_W = 6;
   localparam int DEPTH = 2 ** ADDR_W;
   localparam int CLK_PERIOD = 40;
   localparam int TBL_LEN = 64;
   // two passes over the table, so a stalled sink can fill the fifo
   localparam int N_BYTES = 2 * TBL_LEN;
   localparam int N_WORDS = N_BYTES / RATIO;
   localparam int STALL_CYC = 40;
   localparam int STALL_LIMIT = 1500;
   localparam int BLOCK_CYC = 16;
   // source keeps the request up this long after the ack
   localparam int REQ_HOLD_CYC = 2;
   // source idles this long between requests
   localparam int REQ_GAP_CYC = 1;
   // sink keeps the ack up this long after the request drops
   localparam int REL_CYC = 2;
   localparam int WATCHDOG_NS = N_BYTES * (8 + STALL_CYC) * CLK_PERIOD
                                + STALL_LIMIT * CLK_PERIOD;

   // sink delay classes
   localparam int D_NONE = 0;
   localparam int D_RAND = 1;
   localparam int D_STALL = 2;

   logic  w_clk_i;
   logic  r_clk_i;
   logic  arst_n_i;
   logic  in_req_i;
   byte_t in_data_i;
   logic  in_ack_o;
   logic  out_req_o;
   word_t out_data_o;
   logic  out_ack_i;

   // byte values, walked in order
   byte_t tbl_data [TBL_LEN] = '{
      8'h11, 8'h22, 8'h33, 8'h44, 8'hde, 8'had, 8'hbe, 8'hef,
      8'h00, 8'hff, 8'h5a, 8'ha5, 8'h01, 8'h02, 8'h04, 8'h08,
      8'h10, 8'h20, 8'h40, 8'h80, 8'hc3, 8'h3c, 8'h96, 8'h69,
      8'h7e, 8'he7, 8'h12, 8'h34, 8'h56, 8'h78, 8'h9a, 8'hbc,
      8'hfe, 8'hdc, 8'hba, 8'h98, 8'h0f, 8'hf0, 8'h55, 8'haa,
      8'h13, 8'h57, 8'h9b, 8'hdf, 8'h24, 8'h68, 8'hac, 8'he0,
      8'h31, 8'h41, 8'h59, 8'h26, 8'h53, 8'h58, 8'h97, 8'h93,
      8'h23, 8'h84, 8'h62, 8'h64, 8'h33, 8'h83, 8'h27, 8'h95
   };

   // the sink uses the class of a word's first byte
   int dly_tbl [TBL_LEN] = '{
      D_NONE,  D_NONE,  D_NONE,  D_NONE,  D_NONE,  D_NONE,  D_NONE,  D_NONE,
      D_NONE,  D_NONE,  D_NONE,  D_NONE,  D_NONE,  D_NONE,  D_NONE,  D_NONE,
      D_STALL, D_STALL, D_STALL, D_STALL, D_RAND,  D_RAND,  D_RAND,  D_RAND,
      D_RAND,  D_RAND,  D_RAND,  D_RAND,  D_NONE,  D_NONE,  D_NONE,  D_NONE,
      D_RAND,  D_RAND,  D_RAND,  D_RAND,  D_RAND,  D_RAND,  D_RAND,  D_RAND,
      D_NONE,  D_NONE,  D_NONE,  D_NONE,  D_RAND,  D_RAND,  D_RAND,  D_RAND,
      D_RAND,  D_RAND,  D_RAND,  D_RAND,  D_RAND,  D_RAND,  D_RAND,  D_RAND,
      D_NONE,  D_NONE,  D_NONE,  D_NONE,  D_RAND,  D_RAND,  D_RAND,  D_RAND
   };

   int   n_accepted = 0;
   int   words_seen = 0;
   int   stuck_cnt = 0;
   bit   src_done = 1'b0;
   bit   src_blocked = 1'b0;
   bit   bp_seen = 1'b0;
   logic ack_q = 1'b0;
   logic oreq_q = 1'b0;

   stream_width_top #(.ADDR_W(ADDR_W)) dut_i (
      .w_clk_i    (w_clk_i),
      .r_clk_i    (r_clk_i),
      .arst_n_i   (arst_n_i),
      .in_req_i   (in_req_i),
      .in_data_i  (in_data_i),
      .in_ack_o   (in_ack_o),
      .out_req_o  (out_req_o),
      .out_data_o (out_data_o),
      .out_ack_i  (out_ack_i)
   );

   initial begin
      w_clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) w_clk_i = ~w_clk_i;
   end

   // read clock offset so edges never line up
   initial begin
      r_clk_i = 1'b0;
      #13;
      forever #(CLK_PERIOD / 2) r_clk_i = ~r_clk_i;
   end

   task automatic stop_with_failure();
      $display("** FAIL **");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("FAIL %s: expected 0x%h, got 0x%h", name, exp, act);
         stop_with_failure();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("FAIL %s: expected 0x%h, got 0x%h", name, exp, act);
         stop_with_failure();
      end
   endtask

   // first byte of the group lands in bits 7:0
   function automatic word_t pack_word(input int w);
      word_t wd;
      int    base;
      base = (w * RATIO) % TBL_LEN;
      for (int k = 0; k < RATIO; k++) begin
         wd[k*BYTE_W +: BYTE_W] = tbl_data[base + k];
      end
      return wd;
   endfunction

   // request must stay up with the word unchanged
   task automatic hold_word(input int n, input word_t exp);
      repeat (n) begin
         @(posedge r_clk_i);
         check_bit("out_req_o", 1'b1, out_req_o);
         check_word("out_data_o", exp, out_data_o);
      end
   endtask

   task automatic drive_source();
      for (int i = 0; i < N_BYTES; i++) begin
         in_req_i  <= 1'b1;
         in_data_i <= tbl_data[i % TBL_LEN];
         @(posedge w_clk_i);
         while (!in_ack_o) begin
            @(posedge w_clk_i);
         end
         n_accepted++;
         // an ack that drops on its own shows up here
         repeat (REQ_HOLD_CYC) @(posedge w_clk_i);
         in_req_i <= 1'b0;
         @(posedge w_clk_i);
         while (in_ack_o) begin
            @(posedge w_clk_i);
         end
         // idle gap, a stray ack would rise here
         repeat (REQ_GAP_CYC) @(posedge w_clk_i);
      end
      src_done = 1'b1;
   endtask

   task automatic run_sink();
      word_t exp;
      int    cls;
      int    dly;
      int    waited;
      for (int w = 0; w < N_WORDS; w++) begin
         @(posedge r_clk_i);
         while (!out_req_o) begin
            @(posedge r_clk_i);
         end
         exp = pack_word(w);
         words_seen++;
         check_word("out_data_o", exp, out_data_o);
         cls = dly_tbl[(w * RATIO) % TBL_LEN];
         if (cls == D_RAND) begin
            dly = int'($urandom % 8);
            hold_word(dly, exp);
         end else if (cls == D_STALL) begin
            waited = 0;
            while (!src_blocked && !src_done && waited < STALL_LIMIT) begin
               hold_word(1, exp);
               waited++;
            end
            if (waited == STALL_LIMIT) begin
               $display("sink stall saw neither back-pressure nor the end of the source");
               stop_with_failure();
            end
            if (src_blocked) begin
               bp_seen = 1'b1;
               // bytes sitting in the fifo when the source got stuck
               if (n_accepted - RATIO * words_seen > DEPTH) begin
                  $display("source kept being acknowledged past the fifo depth");
                  stop_with_failure();
               end
            end
            hold_word(STALL_CYC, exp);
         end
         out_ack_i <= 1'b1;
         @(posedge r_clk_i);
         while (out_req_o) begin
            check_word("out_data_o", exp, out_data_o);
            @(posedge r_clk_i);
         end
         // ack lingers so an early new request gets caught
         repeat (REL_CYC) @(posedge r_clk_i);
         out_ack_i <= 1'b0;
      end
   endtask

   // input side four-phase order, plus stuck request detection
   always @(posedge w_clk_i) begin
      if (arst_n_i) begin
         if (in_ack_o && !ack_q) begin
            check_bit("in_req_i", 1'b1, in_req_i);
         end
         if (!in_ack_o && ack_q) begin
            check_bit("in_req_i", 1'b0, in_req_i);
         end
         if (in_req_i && !in_ack_o) begin
            stuck_cnt++;
         end else begin
            stuck_cnt = 0;
         end
         src_blocked = (stuck_cnt > BLOCK_CYC);
      end
      ack_q = in_ack_o;
   end

   // no new request while the sink still acknowledges
   always @(posedge r_clk_i) begin
      if (arst_n_i && out_req_o && !oreq_q) begin
         check_bit("out_ack_i", 1'b0, out_ack_i);
      end
      oreq_q = out_req_o;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired, the run hung before all words arrived");
      stop_with_failure();
   end

   initial begin
      void'($urandom(14));
      arst_n_i  = 1'b0;
      in_req_i  = 1'b0;
      in_data_i = '0;
      out_ack_i = 1'b0;
      repeat (4) @(posedge w_clk_i);
      arst_n_i <= 1'b1;
      // quiet outputs until the first request
      repeat (4) begin
         @(posedge w_clk_i);
         check_bit("in_ack_o", 1'b0, in_ack_o);
         check_bit("out_req_o", 1'b0, out_req_o);
      end
      fork
         drive_source();
         run_sink();
      join
      // nothing left over, nothing duplicated
      repeat (8) begin
         @(posedge r_clk_i);
         check_bit("out_req_o", 1'b0, out_req_o);
      end
      if (bp_seen) begin
         $display("** PASS **");
         $finish;
      end else begin
         $display("the sink stall never pushed back on the source");
         stop_with_failure();
      end
   end

endmodule

`default_nettype wire

// File: hdl/stream_width_top.sv
`timescale 1ns/1ps
`default_nettype none

module stream_width_top
   import afifo_pkg::*;
#(
   parameter int ADDR_W = DEF_ADDR_W
) (
   input  wire logic  w_clk_i,
   input  wire logic  r_clk_i,
   input  wire logic  arst_n_i,
   // byte source, write clock
   input  wire logic  in_req_i,
   input  wire byte_t in_data_i,
   output logic       in_ack_o,
   // word sink, read clock
   output logic       out_req_o,
   output word_t      out_data_o,
   input  wire logic  out_ack_i
);

   fifo_wr_if #(.ADDR_W(ADDR_W)) wr_if ();
   fifo_rd_if #(.ADDR_W(ADDR_W)) rd_if ();

   byte_producer #(.ADDR_W(ADDR_W)) producer_i (
      .w_clk_i   (w_clk_i),
      .arst_n_i  (arst_n_i),
      .in_req_i  (in_req_i),
      .in_data_i (in_data_i),
      .in_ack_o  (in_ack_o),
      .wr        (wr_if.producer)
   );

   async_fifo_asym #(.ADDR_W(ADDR_W)) fifo_i (
      .w_clk_i  (w_clk_i),
      .r_clk_i  (r_clk_i),
      .arst_n_i (arst_n_i),
      .wr       (wr_if.fifo),
      .rd       (rd_if.fifo)
   );

   word_consumer #(.ADDR_W(ADDR_W)) consumer_i (
      .r_clk_i    (r_clk_i),
      .arst_n_i   (arst_n_i),
      .rd         (rd_if.consumer),
      .out_req_o  (out_req_o),
      .out_data_o (out_data_o),
      .out_ack_i  (out_ack_i)
   );

endmodule

`default_nettype wire

// File: hdl/word_consumer.sv
`timescale 1ns/1ps
`default_nettype none

module word_consumer
   import afifo_pkg::*;
#(
   parameter int ADDR_W = DEF_ADDR_W
) (
   input  wire logic  r_clk_i,
   input  wire logic  arst_n_i,
   fifo_rd_if.consumer rd,
   output logic       out_req_o,
   output word_t      out_data_o,
   input  wire logic  out_ack_i
);

   localparam logic [ADDR_W:0] WORD_BYTES = (ADDR_W + 1)'(RATIO);

   hs_st_e st_q;
   logic   pop;

   // only whole words leave the fifo
   assign pop = (st_q == HS_IDLE) && !rd.r_empty && (rd.r_level >= WORD_BYTES);

   assign rd.r_en = pop;

   always_ff @(posedge r_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         st_q      <= HS_IDLE;
         out_req_o <= 1'b0;
      end else begin
         case (st_q)
            HS_IDLE: begin
               if (pop) begin
                  st_q <= HS_XFER;
               end
            end
            HS_XFER: begin
               // read data valid now, captured below
               out_req_o <= 1'b1;
               st_q      <= HS_HOLD;
            end
            HS_HOLD: begin
               if (out_ack_i) begin
                  out_req_o <= 1'b0;
                  st_q      <= HS_WAIT_REL;
               end
            end
            HS_WAIT_REL: begin
               // no new pop until the sink lets go
               if (!out_ack_i) begin
                  st_q <= HS_IDLE;
               end
            end
            default: st_q <= HS_IDLE;
         endcase
      end
   end

   // word stays put for the whole four-phase cycle
   always_ff @(posedge r_clk_i) begin
      if (st_q == HS_XFER) begin
         out_data_o <= rd.r_data;
      end
   end

endmodule

`default_nettype wire

// File: hdl/byte_producer.sv
`timescale 1ns/1ps
`default_nettype none

module byte_producer
   import afifo_pkg::*;
#(
   parameter int ADDR_W = DEF_ADDR_W
) (
   input  wire logic  w_clk_i,
   input  wire logic  arst_n_i,
   input  wire logic  in_req_i,
   input  wire byte_t in_data_i,
   output logic       in_ack_o,
   fifo_wr_if.producer wr
);

   localparam logic [ADDR_W:0] FIFO_SIZE = {1'b1, {ADDR_W{1'b0}}};

   hs_st_e st_q;
   logic   room;
   logic   push;

   // room for another byte
   assign room = !wr.w_full && (wr.w_level < FIFO_SIZE);

   // one write per request; stalls here while full, ack stays low
   assign push = (st_q == HS_IDLE) && in_req_i && room;

   assign wr.w_en   = push;
   assign wr.w_data = in_data_i;

   always_ff @(posedge w_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         st_q     <= HS_IDLE;
         in_ack_o <= 1'b0;
      end else begin
         case (st_q)
            HS_IDLE: begin
               if (push) begin
                  st_q <= HS_XFER;
               end
            end
            HS_XFER: begin
               // byte is in the fifo now
               in_ack_o <= 1'b1;
               st_q     <= HS_WAIT_REL;
            end
            HS_WAIT_REL: begin
               if (!in_req_i) begin
                  in_ack_o <= 1'b0;
                  st_q     <= HS_IDLE;
               end
            end
            default: st_q <= HS_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/async_fifo_asym.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo_asym
   import afifo_pkg::*;
#(
   parameter int ADDR_W = DEF_ADDR_W
) (
   input  wire logic w_clk_i,
   input  wire logic r_clk_i,
   input  wire logic arst_n_i,
   fifo_wr_if.fifo   wr,
   fifo_rd_if.fifo   rd
);

   localparam int R_ADDR_W = ADDR_W - RATIO_LOG2;
   localparam logic [ADDR_W:0] FIFO_SIZE = {1'b1, {ADDR_W{1'b0}}};
   localparam logic [ADDR_W:0] W_INCR = (ADDR_W + 1)'(1);
   localparam logic [ADDR_W:0] R_INCR = (ADDR_W + 1)'(RATIO);

   // narrow gray pointers zero-extend without changing their binary value
   function automatic logic [ADDR_W-1:0] gray2bin(input logic [ADDR_W-1:0] gray);
      logic [ADDR_W-1:0] bin;
      for (int i = 0; i < ADDR_W; i++) begin
         bin[i] = ^(gray >> i);
      end
      return bin;
   endfunction

   logic                w_en_int;
   logic                r_en_int;
   logic [ADDR_W-1:0]   w_waddr_bin;
   logic [ADDR_W-1:0]   w_waddr_gray;
   logic [ADDR_W-1:0]   r_waddr_gray;
   logic [ADDR_W-1:0]   r_waddr_bin;
   logic [R_ADDR_W-1:0] r_raddr_bin;
   logic [R_ADDR_W-1:0] r_raddr_gray;
   logic [R_ADDR_W-1:0] w_raddr_gray;
   // pointers in byte units
   logic [ADDR_W-1:0]   w_raddr_bin_n;
   logic [ADDR_W-1:0]   r_raddr_bin_n;
   logic [ADDR_W-1:0]   w_level_int;
   logic [ADDR_W-1:0]   r_level_int;
   logic [ADDR_W:0]     w_level_ext;
   logic [ADDR_W:0]     r_level_ext;
   fifo_wr_st_e         w_st_q;
   fifo_wr_st_e         w_st_nxt;
   fifo_rd_st_e         r_st_q;
   fifo_rd_st_e         r_st_nxt;

   assign w_en_int = wr.w_en & ~wr.w_full;
   assign r_en_int = rd.r_en & ~rd.r_empty;

   gray_ptr_counter #(.W(ADDR_W)) w_ptr_i (
      .clk_i    (w_clk_i),
      .arst_n_i (arst_n_i),
      .en_i     (w_en_int),
      .gray_o   (w_waddr_gray),
      .bin_o    (w_waddr_bin)
   );

   gray_ptr_counter #(.W(R_ADDR_W)) r_ptr_i (
      .clk_i    (r_clk_i),
      .arst_n_i (arst_n_i),
      .en_i     (r_en_int),
      .gray_o   (r_raddr_gray),
      .bin_o    (r_raddr_bin)
   );

   // write pointer into read domain
   cdc_sync #(.DATA_W(ADDR_W)) w2r_sync_i (
      .clk_i    (r_clk_i),
      .arst_n_i (arst_n_i),
      .signal_i (w_waddr_gray),
      .signal_o (r_waddr_gray)
   );

   // read pointer into write domain
   cdc_sync #(.DATA_W(R_ADDR_W)) r2w_sync_i (
      .clk_i    (w_clk_i),
      .arst_n_i (arst_n_i),
      .signal_i (r_raddr_gray),
      .signal_o (w_raddr_gray)
   );

   assign r_waddr_bin   = gray2bin(r_waddr_gray);
   assign w_raddr_bin_n = gray2bin(ADDR_W'(w_raddr_gray)) << RATIO_LOG2;
   assign r_raddr_bin_n = ADDR_W'(r_raddr_bin) << RATIO_LOG2;

   // zero here is either empty or full, the state decides which
   assign w_level_int = w_waddr_bin - w_raddr_bin_n;
   assign r_level_int = r_waddr_bin - r_raddr_bin_n;
   assign w_level_ext = {1'b0, w_level_int};
   assign r_level_ext = {1'b0, r_level_int};

   always_ff @(posedge w_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         w_st_q <= WR_INIT;
      end else begin
         w_st_q <= w_st_nxt;
      end
   end

   // full in init too, blocks writes for the first cycle
   assign wr.w_full = (w_st_q != WR_DEFAULT);

   always_comb begin
      w_st_nxt   = w_st_q;
      wr.w_level = w_level_ext;
      case (w_st_q)
         WR_INIT: w_st_nxt = WR_DEFAULT;
         WR_DEFAULT: begin
            if (w_en_int && (w_level_ext + W_INCR) > (FIFO_SIZE - W_INCR)) begin
               w_st_nxt = WR_FULL;
            end
         end
         WR_FULL: begin
            if (w_level_int == '0) begin
               wr.w_level = FIFO_SIZE;
            end else if (w_level_ext <= (FIFO_SIZE - W_INCR)) begin
               w_st_nxt = WR_DEFAULT;
            end
         end
         default: w_st_nxt = WR_INIT;
      endcase
   end

   always_ff @(posedge r_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_st_q <= RD_INIT;
      end else begin
         r_st_q <= r_st_nxt;
      end
   end

   assign rd.r_empty = (r_st_q != RD_DEFAULT);

   always_comb begin
      r_st_nxt   = r_st_q;
      rd.r_level = r_level_ext;
      case (r_st_q)
         RD_INIT: r_st_nxt = RD_EMPTY;
         RD_EMPTY: begin
            // wait for one complete word
            if (r_level_ext >= R_INCR) begin
               r_st_nxt = RD_DEFAULT;
            end
         end
         RD_DEFAULT: begin
            if (r_level_int == '0) begin
               rd.r_level = FIFO_SIZE;
            end else if (r_en_int && (r_level_ext - R_INCR) < R_INCR) begin
               r_st_nxt = RD_EMPTY;
            end
         end
         default: r_st_nxt = RD_INIT;
      endcase
   end

   ram_t2p_asym #(.ADDR_W(ADDR_W)) ram_i (
      .w_clk_i  (w_clk_i),
      .w_en_i   (w_en_int),
      .w_addr_i (w_waddr_bin),
      .w_data_i (wr.w_data),
      .r_clk_i  (r_clk_i),
      .r_en_i   (r_en_int),
      .r_addr_i (r_raddr_bin),
      .r_data_o (rd.r_data)
   );

endmodule

`default_nettype wire

// File: hdl/ram_t2p_asym.sv
`timescale 1ns/1ps
`default_nettype none

module ram_t2p_asym
   import afifo_pkg::*;
#(
   parameter int ADDR_W = DEF_ADDR_W
) (
   // byte write port
   input  wire logic                         w_clk_i,
   input  wire logic                         w_en_i,
   input  wire logic [ADDR_W-1:0]            w_addr_i,
   input  wire byte_t                        w_data_i,
   // word read port
   input  wire logic                         r_clk_i,
   input  wire logic                         r_en_i,
   input  wire logic [ADDR_W-RATIO_LOG2-1:0] r_addr_i,
   output word_t                             r_data_o
);

   localparam int WORDS = 2 ** (ADDR_W - RATIO_LOG2);

   // lane 0 sits in bits 7:0, so bytes pack little-endian
   logic [RATIO-1:0][BYTE_W-1:0] mem [WORDS];

   logic [ADDR_W-RATIO_LOG2-1:0] w_word;
   logic [RATIO_LOG2-1:0]        w_lane;

   assign w_word = w_addr_i[ADDR_W-1:RATIO_LOG2];
   assign w_lane = w_addr_i[RATIO_LOG2-1:0];

   always_ff @(posedge w_clk_i) begin
      if (w_en_i) begin
         mem[w_word][w_lane] <= w_data_i;
      end
   end

   // registered read, word out one edge later
   always_ff @(posedge r_clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

`default_nettype wire

// File: hdl/gray_ptr_counter.sv
`timescale 1ns/1ps
`default_nettype none

module gray_ptr_counter #(
   parameter int W = 4
) (
   input  wire logic         clk_i,
   input  wire logic         arst_n_i,
   input  wire logic         en_i,
   output logic      [W-1:0] gray_o,
   output logic      [W-1:0] bin_o
);

   logic [W-1:0] bin_q;
   logic [W-1:0] bin_nxt;
   logic [W-1:0] gray_q;

   assign bin_nxt = bin_q + W'(1);

   // gray copy is registered so only one bit toggles per step
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         bin_q  <= '0;
         gray_q <= '0;
      end else if (en_i) begin
         bin_q  <= bin_nxt;
         gray_q <= bin_nxt ^ (bin_nxt >> 1);
      end
   end

   assign gray_o = gray_q;

   // local domain uses this directly, no conversion needed
   assign bin_o = bin_q;

endmodule

`default_nettype wire

// File: hdl/cdc_sync.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_sync #(
   parameter int DATA_W = 1
) (
   input  wire logic              clk_i,
   input  wire logic              arst_n_i,
   input  wire logic [DATA_W-1:0] signal_i,
   output logic      [DATA_W-1:0] signal_o
);

   logic [DATA_W-1:0] meta_q;
   logic [DATA_W-1:0] sync_q;

   // first stage may go metastable, second one settles it
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= signal_i;
         sync_q <= meta_q;
      end
   end

   assign signal_o = sync_q;

endmodule

`default_nettype wire

// File: hdl/fifo_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fifo_rd_if
   import afifo_pkg::*;
#(
   parameter int ADDR_W = DEF_ADDR_W
) ();

   logic            r_en;
   // valid the edge after the read
   word_t           r_data;
   logic            r_empty;
   logic [ADDR_W:0] r_level;

   modport consumer (output r_en, input r_data, input r_empty, input r_level);

   modport fifo (input r_en, output r_data, output r_empty, output r_level);

endinterface

`default_nettype wire

// File: hdl/fifo_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fifo_wr_if
   import afifo_pkg::*;
#(
   parameter int ADDR_W = DEF_ADDR_W
) ();

   logic            w_en;
   byte_t           w_data;
   logic            w_full;
   // level in bytes, one extra bit so a full fifo fits
   logic [ADDR_W:0] w_level;

   modport producer (output w_en, output w_data, input w_full, input w_level);

   modport fifo (input w_en, input w_data, output w_full, output w_level);

endinterface

`default_nettype wire

// File: hdl/afifo_pkg.sv
`default_nettype none

package afifo_pkg;

   // stream widths
   localparam int BYTE_W = 8;
   localparam int WORD_W = 32;
   localparam int RATIO = WORD_W / BYTE_W;
   localparam int RATIO_LOG2 = $clog2(RATIO);

   // depth in bytes is 2**ADDR_W
   localparam int DEF_ADDR_W = 6;

   typedef logic [BYTE_W-1:0] byte_t;
   typedef logic [WORD_W-1:0] word_t;

   // fifo write side
   typedef enum logic [1:0] {WR_INIT, WR_DEFAULT, WR_FULL} fifo_wr_st_e;

   // fifo read side
   typedef enum logic [1:0] {RD_INIT, RD_EMPTY, RD_DEFAULT} fifo_rd_st_e;

   // four-phase handshake, used on both stream ends
   typedef enum logic [1:0] {HS_IDLE, HS_XFER, HS_WAIT_REL, HS_HOLD} hs_st_e;

endpackage

`default_nettype wire
